// File: include/mem_bus_params.svh
`ifndef MEM_BUS_PARAMS_SVH
`define MEM_BUS_PARAMS_SVH

// ********************
// bus widths
// ********************
`define MEM_ADDR_W 32
`define MEM_DATA_W 64
`define MEM_STRB_W 8
`define MEM_RESP_W 2

// ********************
// cacheable window
// ********************
// everything outside [base, limit) goes out as uncached
`define MEM_CACHE_BASE  32'h8000_0000
`define MEM_CACHE_LIMIT 32'h8800_0000

`endif

// File: src/mem_bus_pkg.sv
`include "mem_bus_params.svh"

package mem_bus_pkg;

    // request opcode, fetch only ever reads
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // which port owns the outstanding transaction
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_FETCH = 2'd1,
        ARB_DATA  = 2'd2
    } arb_state_e;

    typedef struct packed {
        mem_op_e                 op;
        logic [`MEM_ADDR_W-1:0]  addr;
        logic [`MEM_DATA_W-1:0]  wdata;
        logic [`MEM_STRB_W-1:0]  wstrb;
    } bus_req_t;

    typedef struct packed {
        logic [`MEM_DATA_W-1:0]  rdata;
        logic [`MEM_RESP_W-1:0]  resp;
    } bus_resp_t;

    // request as seen on the memory port
    typedef struct packed {
        bus_req_t req;
        logic     uncached;
    } mem_req_t;

endpackage

// File: src/req_slot.sv
`timescale 1ns/1ps

`include "mem_bus_params.svh"

module req_slot
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    // requester side
    input  logic     req_valid_i,
    input  bus_req_t req_i,
    output logic     req_ready_o,

    // arbiter side
    input  logic     take_i,
    output logic     full_o,
    output bus_req_t req_o
);

    logic     full_q;
    bus_req_t req_q;

    // one entry, so accept only when empty
    assign req_ready_o = ~full_q;
    assign full_o      = full_q;
    assign req_o       = req_q;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            full_q <= 1'b0;
        end else if (req_valid_i && req_ready_o) begin
            full_q <= 1'b1;
        end else if (take_i) begin
            full_q <= 1'b0;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
    end

endmodule

// File: src/bus_arbiter.sv
`timescale 1ns/1ps

`include "mem_bus_params.svh"

module bus_arbiter
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // request slots
    input  logic      fetch_full_i,
    input  logic      data_full_i,
    input  bus_req_t  fetch_req_i,
    input  bus_req_t  data_req_i,
    output logic      fetch_take_o,
    output logic      data_take_o,

    // toward the memory master
    output logic      issue_o,
    output bus_req_t  issue_req_o,

    // response from memory
    input  logic      mem_resp_valid_i,
    input  bus_resp_t mem_resp_i,
    output logic      fetch_resp_valid_o,
    output logic      data_resp_valid_o,
    output bus_resp_t resp_o
);

    arb_state_e state_q;
    arb_state_e state_d;

    // ********************
    // grant selection
    // ********************
    // data side wins, fetch waits while load/store traffic is pending
    always_comb begin
        state_d      = state_q;
        fetch_take_o = 1'b0;
        data_take_o  = 1'b0;
        issue_o      = 1'b0;
        issue_req_o  = data_full_i ? data_req_i : fetch_req_i;

        case (state_q)
            ARB_IDLE: begin
                if (data_full_i) begin
                    data_take_o = 1'b1;
                    issue_o     = 1'b1;
                    state_d     = ARB_DATA;
                end else if (fetch_full_i) begin
                    fetch_take_o = 1'b1;
                    issue_o      = 1'b1;
                    state_d      = ARB_FETCH;
                end
            end
            ARB_FETCH, ARB_DATA: begin
                // grant held until the one response comes back
                if (mem_resp_valid_i) begin
                    state_d = ARB_IDLE;
                end
            end
            default: begin
                state_d = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ********************
    // response routing
    // ********************
    // no extra cycle, steer by current grant
    assign fetch_resp_valid_o = mem_resp_valid_i && (state_q == ARB_FETCH);
    assign data_resp_valid_o  = mem_resp_valid_i && (state_q == ARB_DATA);
    assign resp_o             = mem_resp_i;

endmodule

// File: src/mem_master.sv
`timescale 1ns/1ps

`include "mem_bus_params.svh"

module mem_master
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    // from the arbiter
    input  logic     issue_i,
    input  bus_req_t issue_req_i,

    // memory request port
    output logic     mem_req_valid_o,
    output mem_req_t mem_req_o,
    input  logic     mem_req_ready_i
);

    logic     valid_q;
    mem_req_t req_q;
    logic     in_window;
    logic     uncached;

    // ********************
    // uncache decode
    // ********************
    // cacheable only inside [base, limit)
    assign in_window = (issue_req_i.addr >= `MEM_CACHE_BASE) &&
                       (issue_req_i.addr <  `MEM_CACHE_LIMIT);
    assign uncached  = ~in_window;

    // ********************
    // output register
    // ********************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            valid_q <= 1'b0;
        end else if (issue_i) begin
            valid_q <= 1'b1;
        end else if (mem_req_ready_i) begin
            // accepted by memory
            valid_q <= 1'b0;
        end
    end

    // fields stay put until the next issue,
    // which cannot come before the response
    always_ff @(posedge clk) begin
        if (issue_i) begin
            req_q.req      <= issue_req_i;
            req_q.uncached <= uncached;
        end
    end

    assign mem_req_valid_o = valid_q;
    assign mem_req_o       = req_q;

endmodule

// File: src/mem_bus_top.sv
`timescale 1ns/1ps

`include "mem_bus_params.svh"

module mem_bus_top
    import mem_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // instruction fetch, read only
    input  logic                   fetch_req_valid_i,
    input  logic [`MEM_ADDR_W-1:0] fetch_addr_i,
    output logic                   fetch_req_ready_o,
    output logic                   fetch_resp_valid_o,
    output bus_resp_t              fetch_resp_o,

    // load/store unit
    input  logic                   data_req_valid_i,
    input  bus_req_t               data_req_i,
    output logic                   data_req_ready_o,
    output logic                   data_resp_valid_o,
    output bus_resp_t              data_resp_o,

    // memory port
    output logic                   mem_req_valid_o,
    output mem_req_t               mem_req_o,
    input  logic                   mem_req_ready_i,
    input  logic                   mem_resp_valid_i,
    input  bus_resp_t              mem_resp_i
);

    bus_req_t  fetch_req;
    bus_req_t  fetch_held;
    bus_req_t  data_held;
    bus_req_t  issue_req;
    bus_resp_t resp;
    logic      fetch_full;
    logic      data_full;
    logic      fetch_take;
    logic      data_take;
    logic      issue;

    // ********************
    // input side
    // ********************
    // fetch never writes
    assign fetch_req.op    = OP_READ;
    assign fetch_req.addr  = fetch_addr_i;
    assign fetch_req.wdata = '0;
    assign fetch_req.wstrb = '0;

    req_slot u_fetch_slot (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (fetch_req_valid_i),
        .req_i       (fetch_req),
        .req_ready_o (fetch_req_ready_o),
        .take_i      (fetch_take),
        .full_o      (fetch_full),
        .req_o       (fetch_held)
    );

    req_slot u_data_slot (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (data_req_valid_i),
        .req_i       (data_req_i),
        .req_ready_o (data_req_ready_o),
        .take_i      (data_take),
        .full_o      (data_full),
        .req_o       (data_held)
    );

    // ********************
    // arbitration
    // ********************
    bus_arbiter u_arbiter (
        .clk                (clk),
        .rst_n              (rst_n),
        .fetch_full_i       (fetch_full),
        .data_full_i        (data_full),
        .fetch_req_i        (fetch_held),
        .data_req_i         (data_held),
        .fetch_take_o       (fetch_take),
        .data_take_o        (data_take),
        .issue_o            (issue),
        .issue_req_o        (issue_req),
        .mem_resp_valid_i   (mem_resp_valid_i),
        .mem_resp_i         (mem_resp_i),
        .fetch_resp_valid_o (fetch_resp_valid_o),
        .data_resp_valid_o  (data_resp_valid_o),
        .resp_o             (resp)
    );

    // both ports see the same payload, valids tell them apart
    assign fetch_resp_o = resp;
    assign data_resp_o  = resp;

    // ********************
    // output side
    // ********************
    mem_master u_master (
        .clk             (clk),
        .rst_n           (rst_n),
        .issue_i         (issue),
        .issue_req_i     (issue_req),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_req_ready_i (mem_req_ready_i)
    );

endmodule

// File: verification/mem_bus_assert.sv
`timescale 1ns/1ps

`include "mem_bus_params.svh"

module mem_bus_assert
    import mem_bus_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     mem_req_valid_i,
    input mem_req_t mem_req_i,
    input logic     mem_req_ready_i,
    input logic     fetch_resp_valid_i,
    input logic     data_resp_valid_i
);

    // request holds while memory stalls it
    assert property (@(posedge clk) disable iff (rst_n)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
        else $error("memory request dropped or changed while stalled");

    // one owner per response
    assert property (@(posedge clk) disable iff (rst_n)
        !(fetch_resp_valid_i && data_resp_valid_i))
        else $error("fetch and data responses in the same cycle");

    assert property (@(posedge clk) $fell(rst_n) |-> !mem_req_valid_i)
        else $error("memory request valid in the first cycle after reset");

endmodule

bind mem_bus_top mem_bus_assert u_assert (
    .clk                (clk),
    .rst_n              (rst_n),
    .mem_req_valid_i    (mem_req_valid_o),
    .mem_req_i          (mem_req_o),
    .mem_req_ready_i    (mem_req_ready_i),
    .fetch_resp_valid_i (fetch_resp_valid_o),
    .data_resp_valid_i  (data_resp_valid_o)
);

// File: verification/mem_bus_tb.sv
`timescale 1ns/1ps

`include "mem_bus_params.svh"

module mem_bus_tb
    import mem_bus_pkg::*;
();

    localparam logic [1:0] MODE_FETCH = 2'd0;
    localparam logic [1:0] MODE_DATA  = 2'd1;
    localparam logic [1:0] MODE_BOTH  = 2'd2;
    localparam int         NUM_VECS   = 10;
    localparam int         TIMEOUT    = 200;

    typedef struct packed {
        logic [1:0]             mode;
        logic                   stall;
        logic [`MEM_ADDR_W-1:0] fetch_addr;
        bus_req_t               data_req;
        logic [`MEM_DATA_W-1:0] exp_rdata;
        logic [`MEM_RESP_W-1:0] exp_resp;
        logic                   exp_uncached;
    } vec_t;

    logic                   clk = 1'b0;
    logic                   rst_n = 1'b1;
    logic                   fetch_req_valid_i = 1'b0;
    logic [`MEM_ADDR_W-1:0] fetch_addr_i = '0;
    logic                   data_req_valid_i = 1'b0;
    bus_req_t               data_req_i = '0;
    logic                   mem_req_ready_i = 1'b0;
    logic                   mem_resp_valid_i = 1'b0;
    bus_resp_t              mem_resp_i = '0;
    logic                   fetch_req_ready_o;
    logic                   fetch_resp_valid_o;
    bus_resp_t              fetch_resp_o;
    logic                   data_req_ready_o;
    logic                   data_resp_valid_o;
    bus_resp_t              data_resp_o;
    logic                   mem_req_valid_o;
    mem_req_t               mem_req_o;

    // sparse memory model state
    logic [`MEM_DATA_W-1:0] mem_q [logic [`MEM_ADDR_W-1:0]];
    mem_req_t               acc_q [$];
    bus_resp_t              resp_hold;
    logic                   ready_armed = 1'b0;
    logic                   resp_pending = 1'b0;
    logic                   stall_en = 1'b0;
    logic                   timed_out = 1'b0;
    int                     ready_wait;
    int                     resp_wait;
    int                     err_count;
    int                     pass_count;
    int                     fetch_resp_cnt;
    int                     data_resp_cnt;
    int                     fetch_sent;
    int                     data_sent;
    int                     vec_idx;
    vec_t                   vecs [NUM_VECS];

    mem_bus_top u_dut (.*);

    always #4 clk = ~clk;

    // never-written locations read back as the address twice
    function automatic logic [`MEM_DATA_W-1:0] fill_word(input logic [`MEM_ADDR_W-1:0] addr);
        return {addr, addr};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s: expected %0h, got %0h", $time, name, exp, got);
            err_count++;
        end
    endtask

    // ********************
    // memory model
    // ********************
    task automatic serve(input mem_req_t r);
        logic [`MEM_DATA_W-1:0] word;
        int                     b;
        word = mem_q.exists(r.req.addr) ? mem_q[r.req.addr] : fill_word(r.req.addr);
        acc_q.push_back(r);
        resp_hold = '0;
        if (r.req.op == OP_WRITE) begin
            for (b = 0; b < `MEM_STRB_W; b++) begin
                if (r.req.wstrb[b]) begin
                    word[8*b +: 8] = r.req.wdata[8*b +: 8];
                end
            end
            mem_q[r.req.addr] = word;
        end else begin
            resp_hold.rdata = word;
        end
        resp_wait    = $urandom % 4;
        resp_pending = 1'b1;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            mem_req_ready_i  <= 1'b0;
            mem_resp_valid_i <= 1'b0;
            ready_armed  = 1'b0;
            resp_pending = 1'b0;
        end else begin
            mem_resp_valid_i <= 1'b0;
            if (mem_req_valid_o && mem_req_ready_i) begin
                mem_req_ready_i <= 1'b0;
                ready_armed = 1'b0;
                serve(mem_req_o);
            end else if (mem_req_valid_o) begin
                if (!ready_armed) begin
                    ready_wait  = stall_en ? int'($urandom % 6) : 0;
                    ready_armed = 1'b1;
                end
                if (ready_wait == 0) begin
                    mem_req_ready_i <= 1'b1;
                end else begin
                    ready_wait--;
                end
            end
            if (resp_pending) begin
                if (resp_wait == 0) begin
                    mem_resp_valid_i <= 1'b1;
                    mem_resp_i       <= resp_hold;
                    resp_pending = 1'b0;
                end else begin
                    resp_wait--;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_n && fetch_resp_valid_o) begin
            fetch_resp_cnt++;
        end
        if (!rst_n && data_resp_valid_o) begin
            data_resp_cnt++;
        end
    end

    // ********************
    // stimulus table
    // ********************
    task automatic load_table();
        // mode, stall, fetch addr, op, addr, wdata, wstrb, exp rdata, exp resp, exp uncached
        vecs[0] = {MODE_FETCH, 1'b0, 32'h8000_0100, OP_READ, 32'h0, 64'h0, 8'h00,
                   {2{32'h8000_0100}}, 2'b00, 1'b0};
        vecs[1] = {MODE_DATA, 1'b0, 32'h0, OP_WRITE, 32'h8000_0200, 64'h1122_3344_5566_7788,
                   8'hff, 64'h0, 2'b00, 1'b0};
        vecs[2] = {MODE_DATA, 1'b0, 32'h0, OP_WRITE, 32'h8000_0200, 64'haaaa_bbbb_cccc_dddd,
                   8'h0f, 64'h0, 2'b00, 1'b0};
        vecs[3] = {MODE_DATA, 1'b0, 32'h0, OP_READ, 32'h8000_0200, 64'h0, 8'h00,
                   64'h1122_3344_cccc_dddd, 2'b00, 1'b0};
        vecs[4] = {MODE_FETCH, 1'b0, 32'h7fff_fffc, OP_READ, 32'h0, 64'h0, 8'h00,
                   {2{32'h7fff_fffc}}, 2'b00, 1'b1};
        vecs[5] = {MODE_DATA, 1'b0, 32'h0, OP_READ, 32'h8000_0000, 64'h0, 8'h00,
                   {2{32'h8000_0000}}, 2'b00, 1'b0};
        vecs[6] = {MODE_DATA, 1'b1, 32'h0, OP_READ, 32'h8800_0000, 64'h0, 8'h00,
                   {2{32'h8800_0000}}, 2'b00, 1'b1};
        vecs[7] = {MODE_BOTH, 1'b1, 32'h1000_0000, OP_READ, 32'hffff_0000, 64'h0, 8'h00,
                   {2{32'hffff_0000}}, 2'b00, 1'b1};
        vecs[8] = {MODE_BOTH, 1'b1, 32'h87ff_fff8, OP_WRITE, 32'h8000_0200, 64'h0, 8'hf0,
                   64'h0, 2'b00, 1'b0};
        vecs[9] = {MODE_DATA, 1'b1, 32'h0, OP_READ, 32'h8000_0200, 64'h0, 8'h00,
                   64'h0000_0000_cccc_dddd, 2'b00, 1'b0};
    endtask

    task automatic run_entry(input int idx, input vec_t v);
        logic      f_on;
        logic      d_on;
        logic      f_wait;
        logic      d_wait;
        logic      f_go;
        logic      d_go;
        bus_resp_t f_resp;
        bus_resp_t d_resp;
        bus_resp_t prim;
        string     rdata_name;
        string     code_name;
        int        guard;
        int        errs;
        errs     = err_count;
        f_on     = (v.mode != MODE_DATA);
        d_on     = (v.mode != MODE_FETCH);
        f_wait   = f_on;
        d_wait   = d_on;
        f_resp   = '0;
        d_resp   = '0;
        guard    = 0;
        stall_en = v.stall;
        acc_q.delete();
        fetch_sent += f_on;
        data_sent  += d_on;
        @(posedge clk);
        fetch_req_valid_i <= f_on;
        fetch_addr_i      <= v.fetch_addr;
        data_req_valid_i  <= d_on;
        data_req_i        <= v.data_req;
        // handshakes first and then one response per launched request
        while ((f_on || d_on || f_wait || d_wait) && guard < TIMEOUT) begin
            @(negedge clk);
            if (fetch_resp_valid_o) begin
                f_resp = fetch_resp_o;
                f_wait = 1'b0;
            end
            if (data_resp_valid_o) begin
                d_resp = data_resp_o;
                d_wait = 1'b0;
            end
            f_go = f_on && fetch_req_ready_o;
            d_go = d_on && data_req_ready_o;
            @(posedge clk);
            if (f_go) begin
                fetch_req_valid_i <= 1'b0;
                f_on = 1'b0;
            end
            if (d_go) begin
                data_req_valid_i <= 1'b0;
                d_on = 1'b0;
            end
            guard++;
        end
        if (f_on || d_on || f_wait || d_wait) begin
            $display("entry %0d: no handshake or response within %0d cycles", idx, TIMEOUT);
            timed_out = 1'b1;
            err_count++;
            return;
        end
        if (v.mode == MODE_FETCH) begin
            prim       = f_resp;
            rdata_name = "fetch_resp_o.rdata";
            code_name  = "fetch_resp_o.resp";
        end else begin
            prim       = d_resp;
            rdata_name = "data_resp_o.rdata";
            code_name  = "data_resp_o.resp";
        end
        check_value(rdata_name, prim.rdata, v.exp_rdata);
        check_value(code_name, prim.resp, v.exp_resp);
        check_value("mem_req_valid_o handshakes", acc_q.size(),
                    (v.mode == MODE_BOTH) ? 2 : 1);
        if (acc_q.size() > 0) begin
            check_value("mem_req_o.uncached", acc_q[0].uncached, v.exp_uncached);
            check_value("mem_req_o.req.addr", acc_q[0].req.addr,
                        (v.mode == MODE_FETCH) ? v.fetch_addr : v.data_req.addr);
            check_value("mem_req_o.req.op", acc_q[0].req.op,
                        (v.mode == MODE_FETCH) ? OP_READ : v.data_req.op);
        end
        // data wins so fetch goes out second
        if (v.mode == MODE_BOTH) begin
            check_value("fetch_resp_o.rdata", f_resp.rdata, fill_word(v.fetch_addr));
            if (acc_q.size() > 1) begin
                check_value("second mem_req_o.req.addr", acc_q[1].req.addr, v.fetch_addr);
            end
        end
        if (err_count == errs) begin
            pass_count++;
        end
        $display("entry %0d: %s", idx, (err_count == errs) ? "ok" : "mismatch");
    endtask

    initial begin
        void'($urandom(32'hec0a_e2d8));
        load_table();
        repeat (3) @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        check_value("fetch_req_ready_o", fetch_req_ready_o, 1'b1);
        check_value("data_req_ready_o", data_req_ready_o, 1'b1);
        check_value("mem_req_valid_o", mem_req_valid_o, 1'b0);
        $display("reset: %s", (err_count == 0) ? "ok" : "mismatch");
        for (vec_idx = 0; vec_idx < NUM_VECS && !timed_out; vec_idx++) begin
            run_entry(vec_idx, vecs[vec_idx]);
        end
        // stray responses would show up here
        repeat (8) @(negedge clk);
        check_value("fetch_resp_valid_o count", fetch_resp_cnt, fetch_sent);
        check_value("data_resp_valid_o count", data_resp_cnt, data_sent);
        $display("summary: %0d entries, %0d passed, %0d errors", NUM_VECS, pass_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: mem_bus_top.f
+incdir+include
src/mem_bus_pkg.sv
src/req_slot.sv
src/bus_arbiter.sv
src/mem_master.sv
src/mem_bus_top.sv
verification/mem_bus_assert.sv
verification/mem_bus_tb.sv

// File: Bender.yml
package:
  name: mem_bus

export_include_dirs:
  - include

sources:
  - files:
      - src/mem_bus_pkg.sv
      - src/req_slot.sv
      - src/bus_arbiter.sv
      - src/mem_master.sv
      - src/mem_bus_top.sv
  - target: test
    files:
      - verification/mem_bus_assert.sv
      - verification/mem_bus_tb.sv
